// ==== Makefile ====
# Verilator build and run for the convolution layer testbench

VERILATOR ?= verilator
TOP       ?= tb_conv_top
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_TEXT ?= Testbench passed

SIM     = $(OBJ_DIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST)) conv_consts.svh

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the simulation prints the pass line
run: compile
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// ==== apb_ctrl.sv ====
`default_nettype none

`include "conv_consts.svh"

module apb_ctrl (
	input  wire                           clk,
	input  wire                           arst_n,
	input  wire [7:0]                     paddr,
	input  wire                           psel,
	input  wire                           penable,
	input  wire                           pwrite,
	input  wire [31:0]                    pwdata,
	output logic [31:0]                   prdata,
	output logic                          pready,
	output logic                          pslverr,
	output logic                          start,
	input  wire                           busy,
	input  wire conv_types_pkg::ofm_vec_t ofm,
	input  wire                           ofm_valid,
	input  wire conv_types_pkg::pos_idx_t ofm_pos,
	input  wire                           layer_done
);

	import conv_types_pkg::*;
	import apb_regs_pkg::*;

	localparam int RES_AW = $clog2(`CONV_RESULTS);

	logic              access;
	logic              hit_ctrl;
	logic              hit_status;
	logic              hit_result;
	logic [RES_AW-1:0] res_idx;
	logic              done;
	logic [7:0]        pos_done;
	status_t           status;
	pixel_t            res_buf [`CONV_RESULTS];

	////////////////////////////////////////////////////////////////////////////
	// Address decode, no wait states
	////////////////////////////////////////////////////////////////////////////

	assign access     = psel && penable;
	assign hit_ctrl   = (paddr == REG_CTRL);
	assign hit_status = (paddr == REG_STATUS);
	assign hit_result = (paddr >= REG_RESULT_BASE) && (paddr[1:0] == 2'b00) &&
		(paddr < REG_RESULT_BASE + 8'(4 * `CONV_RESULTS));
	assign res_idx    = paddr[2 +: RES_AW];

	assign pready  = 1'b1;
	assign start   = access && pwrite && hit_ctrl && pwdata[0];
	// Status and results are read only
	assign pslverr = access && (!(hit_ctrl || hit_status || hit_result) ||
		(pwrite && (hit_status || hit_result)));

	always_comb begin
		status           = '0;
		status.busy      = busy;
		status.done      = done;
		status.positions = pos_done;
	end

	always_comb begin
		prdata = '0;
		if (psel && !pwrite) begin
			if (hit_status) begin
				prdata = status;
			end else if (hit_result) begin
				prdata = 32'(res_buf[res_idx]);
			end
		end
	end

	// A start while busy leaves the previous run's status alone
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			done     <= 1'b0;
			pos_done <= '0;
		end else if (start && !busy) begin
			done     <= 1'b0;
			pos_done <= '0;
		end else begin
			if (layer_done) begin
				done <= 1'b1;
			end
			if (ofm_valid) begin
				pos_done <= pos_done + 1'b1;
			end
		end
	end

	// Result word k = position * lanes + lane
	always_ff @(posedge clk) begin
		if (ofm_valid) begin
			for (int l = 0; l < `CONV_LANES; l++) begin
				res_buf[int'(ofm_pos) * `CONV_LANES + l] <= ofm[l];
			end
		end
	end

endmodule

`default_nettype wire

// ==== apb_regs_pkg.sv ====
`default_nettype none

package apb_regs_pkg;

	// Register map
	localparam logic [7:0] REG_CTRL        = 8'h00;
	localparam logic [7:0] REG_STATUS      = 8'h04;
	localparam logic [7:0] REG_RESULT_BASE = 8'h40;

	typedef struct packed {
		logic [15:0] reserved_hi;
		logic [7:0]  positions;
		logic [5:0]  reserved_lo;
		logic        done;
		logic        busy;
	} status_t;

endpackage

`default_nettype wire

// ==== conv_checker.sv ====
`default_nettype none

`include "conv_consts.svh"

module conv_checker (
	input  wire                         clk,
	input  wire                         arst_n,
	input  wire [7:0]                   paddr,
	input  wire                         psel,
	input  wire                         penable,
	input  wire                         pwrite,
	input  wire [31:0]                  pwdata,
	input  wire [31:0]                  prdata,
	input  wire                         pready,
	input  wire                         pslverr,
	input  wire                         pix_valid,
	input  wire conv_types_pkg::pixel_t pix,
	input  wire                         pix_ready,
	input  wire [2:0]                   test_id,
	input  wire                         status_settled,
	output int                          mismatches,
	output int                          failures
);
	timeunit 1ns;
	timeprecision 1ps;

	import conv_types_pkg::*;
	import apb_regs_pkg::*;

	localparam int RUN_PIXELS = `CONV_POSITIONS * `CONV_TAPS;

	pixel_t pixels [RUN_PIXELS];
	int     accepted;
	logic   running;
	logic   run_done;
	int     mismatch_cnt = 0;
	int     failure_cnt = 0;

	assign mismatches = mismatch_cnt;
	assign failures   = failure_cnt;

	function automatic string test_label(input logic [2:0] id);
		case (id)
			3'd1: return "reset_idle";
			3'd2: return "back_to_back";
			3'd3: return "random_gaps";
			3'd4: return "relu_saturation";
			3'd5: return "status_rerun";
			3'd6: return "apb_errors";
			default: return "setup";
		endcase
	endfunction

	// Layer weights in signed steps of 64
	function automatic longint tap_weight(input int lane, input int tap_n);
		return longint'(((lane * 7 + tap_n * 3) % 17 - 8) * 64);
	endfunction

	// Expected output word for one position and lane
	function automatic int ref_output(input int pos, input int lane);
		longint sum;
		sum = longint'(lane * 4096 - 6000);
		for (int t = 0; t < `CONV_TAPS; t++) begin
			sum += longint'(pixels[pos * `CONV_TAPS + t]) * tap_weight(lane, t);
		end
		if (sum < 0) begin
			return 0;
		end
		sum = sum >>> `CONV_FRAC_SHIFT;
		if (sum > 32767) begin
			return 32767;
		end
		return int'(sum);
	endfunction

	task automatic compare_value(input string what, input logic [31:0] exp,
		input logic [31:0] act);
		if (act !== exp) begin
			$display("mismatch %s %s: expected 0x%08h, actual 0x%08h",
				test_label(test_id), what, exp, act);
			mismatch_cnt++;
		end
	endtask

	task automatic record_pixel();
		if (!running) begin
			$display("A pixel was accepted while the engine was idle in test %s",
				test_label(test_id));
			failure_cnt++;
		end else begin
			pixels[accepted] = pix;
			accepted++;
			if (accepted == RUN_PIXELS) begin
				running  = 1'b0;
				run_done = 1'b1;
			end
		end
	endtask

	task automatic check_apb();
		logic    is_result;
		logic    mapped;
		logic    exp_err;
		status_t exp_status;
		int      k;
		is_result = (paddr >= REG_RESULT_BASE) && (paddr[1:0] == 2'b00) &&
			(int'(paddr) < int'(REG_RESULT_BASE) + 4 * `CONV_RESULTS);
		mapped    = (paddr == REG_CTRL) || (paddr == REG_STATUS) || is_result;
		exp_err   = !mapped || (pwrite && ((paddr == REG_STATUS) || is_result));
		// No wait states on this slave
		compare_value("pready", 32'h1, 32'(pready));
		compare_value("pslverr", 32'(exp_err), 32'(pslverr));
		if (!pwrite && is_result) begin
			k = (int'(paddr) - int'(REG_RESULT_BASE)) / 4;
			compare_value($sformatf("result[%0d]", k),
				32'(ref_output(k / `CONV_LANES, k % `CONV_LANES)), prdata);
		end
		if (!pwrite && (paddr == REG_STATUS) && status_settled) begin
			exp_status           = '0;
			exp_status.busy      = running;
			exp_status.done      = run_done;
			exp_status.positions = 8'(accepted / `CONV_TAPS);
			compare_value("status", exp_status, prdata);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Sampled on the rising edge while inputs change on the falling edge
	////////////////////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		if (!arst_n) begin
			accepted = 0;
			running  = 1'b0;
			run_done = 1'b0;
		end else begin
			compare_value("pix_ready", 32'(running), 32'(pix_ready));
			if (psel && penable) begin
				check_apb();
			end
			if (pix_valid && pix_ready) begin
				record_pixel();
			end
			// Start is ignored while a run is in flight
			if (psel && penable && pwrite && (paddr == REG_CTRL) && pwdata[0] && !running) begin
				running  = 1'b1;
				run_done = 1'b0;
				accepted = 0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== conv_consts.svh ====
`ifndef CONV_CONSTS_SVH
`define CONV_CONSTS_SVH

// Datapath widths
`define CONV_WIDTH       16
`define CONV_ACC_WIDTH   40

// Engine geometry
`define CONV_LANES       4
// 3x3 kernel over 2 input channels
`define CONV_TAPS        18
`define CONV_POSITIONS   4

// Requantization after bias
`define CONV_FRAC_SHIFT  8

// One word per position and lane
`define CONV_RESULTS     16

`endif

// ==== conv_engine.sv ====
`default_nettype none

`include "conv_consts.svh"

module conv_engine (
	input  wire                         clk,
	input  wire                         arst_n,
	input  wire                         start,
	input  wire                         pix_valid,
	input  wire conv_types_pkg::pixel_t pix,
	output logic                        pix_ready,
	output logic                        busy,
	output conv_types_pkg::ofm_vec_t    ofm,
	output logic                        ofm_valid,
	output conv_types_pkg::pos_idx_t    ofm_pos,
	output logic                        layer_done
);

	import conv_types_pkg::*;

	localparam int MAX_OUT = 2 ** (`CONV_WIDTH - 1) - 1;

	typedef struct packed {
		logic valid;
		logic first;
	} tap_ctl_t;

	typedef struct packed {
		logic     last;
		pos_idx_t pos;
	} end_ctl_t;

	logic        accept;
	tap_idx_t    tap;
	tap_flags_t  flags;
	pos_idx_t    pos;
	weight_vec_t weights;
	acc_t        biases [`CONV_LANES];
	pixel_t      pix_d1;
	tap_ctl_t    ctl_in;
	tap_ctl_t    ctl_d1;
	end_ctl_t    end_in;
	end_ctl_t    end_d2;
	acc_t        acc    [`CONV_LANES];
	acc_t        biased [`CONV_LANES];
	acc_t        scaled [`CONV_LANES];
	pixel_t      ofm_next [`CONV_LANES];

	assign accept    = pix_valid && busy;
	assign pix_ready = busy;

	tap_sequencer i_seq (
		.clk    (clk),
		.arst_n (arst_n),
		.start  (start),
		.accept (accept),
		.busy   (busy),
		.tap    (tap),
		.flags  (flags),
		.pos    (pos)
	);

	weight_rom i_rom (
		.clk     (clk),
		.arst_n  (arst_n),
		.tap     (tap),
		.weights (weights),
		.biases  (biases)
	);

	////////////////////////////////////////////////////////////////////////////
	// Alignment with the registered weight lookup
	////////////////////////////////////////////////////////////////////////////

	assign ctl_in.valid = accept;
	assign ctl_in.first = flags.first;
	assign end_in.last  = accept && flags.last;
	assign end_in.pos   = pos;

	pipe_delay #(.T(pixel_t), .DEPTH(1)) i_pix_dly (
		.clk    (clk),
		.arst_n (arst_n),
		.d      (pix),
		.q      (pix_d1)
	);

	pipe_delay #(.T(tap_ctl_t), .DEPTH(1)) i_ctl_dly (
		.clk    (clk),
		.arst_n (arst_n),
		.d      (ctl_in),
		.q      (ctl_d1)
	);

	// Full sum is visible one cycle after the last MAC update
	pipe_delay #(.T(end_ctl_t), .DEPTH(2)) i_end_dly (
		.clk    (clk),
		.arst_n (arst_n),
		.d      (end_in),
		.q      (end_d2)
	);

	for (genvar l = 0; l < `CONV_LANES; l++) begin : g_lane
		mac_lane i_mac (
			.clk    (clk),
			.arst_n (arst_n),
			.en     (ctl_d1.valid),
			.load   (ctl_d1.first),
			.pix    (pix_d1),
			.weight (weights[l]),
			.acc    (acc[l])
		);
	end

	////////////////////////////////////////////////////////////////////////////
	// Bias, ReLU and requantization
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		for (int l = 0; l < `CONV_LANES; l++) begin
			biased[l] = acc[l] + biases[l];
			scaled[l] = biased[l] >>> `CONV_FRAC_SHIFT;
			if (biased[l] < 0) begin
				ofm_next[l] = '0;
			end else if (scaled[l] > acc_t'(MAX_OUT)) begin
				ofm_next[l] = pixel_t'(MAX_OUT);
			end else begin
				ofm_next[l] = pixel_t'(scaled[l]);
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ofm_valid  <= 1'b0;
			ofm_pos    <= '0;
			layer_done <= 1'b0;
		end else begin
			ofm_valid  <= end_d2.last;
			layer_done <= end_d2.last && (end_d2.pos == pos_idx_t'(`CONV_POSITIONS - 1));
			if (end_d2.last) begin
				ofm_pos <= end_d2.pos;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (end_d2.last) begin
			ofm <= ofm_next;
		end
	end

endmodule

`default_nettype wire

// ==== conv_top.sv ====
`default_nettype none

module conv_top (
	input  wire                         clk,
	input  wire                         arst_n,
	input  wire [7:0]                   paddr,
	input  wire                         psel,
	input  wire                         penable,
	input  wire                         pwrite,
	input  wire [31:0]                  pwdata,
	output logic [31:0]                 prdata,
	output logic                        pready,
	output logic                        pslverr,
	input  wire                         pix_valid,
	input  wire conv_types_pkg::pixel_t pix,
	output logic                        pix_ready
);

	import conv_types_pkg::*;

	logic     start;
	logic     busy;
	ofm_vec_t ofm;
	logic     ofm_valid;
	pos_idx_t ofm_pos;
	logic     layer_done;

	// Control and readout
	apb_ctrl i_apb (
		.clk        (clk),
		.arst_n     (arst_n),
		.paddr      (paddr),
		.psel       (psel),
		.penable    (penable),
		.pwrite     (pwrite),
		.pwdata     (pwdata),
		.prdata     (prdata),
		.pready     (pready),
		.pslverr    (pslverr),
		.start      (start),
		.busy       (busy),
		.ofm        (ofm),
		.ofm_valid  (ofm_valid),
		.ofm_pos    (ofm_pos),
		.layer_done (layer_done)
	);

	conv_engine i_engine (
		.clk        (clk),
		.arst_n     (arst_n),
		.start      (start),
		.pix_valid  (pix_valid),
		.pix        (pix),
		.pix_ready  (pix_ready),
		.busy       (busy),
		.ofm        (ofm),
		.ofm_valid  (ofm_valid),
		.ofm_pos    (ofm_pos),
		.layer_done (layer_done)
	);

endmodule

`default_nettype wire

// ==== conv_types_pkg.sv ====
`default_nettype none

`include "conv_consts.svh"

package conv_types_pkg;

	// Scalar datapath types
	typedef logic signed [`CONV_WIDTH-1:0]     pixel_t;
	typedef logic signed [`CONV_WIDTH-1:0]     weight_t;
	typedef logic signed [`CONV_ACC_WIDTH-1:0] acc_t;

	// Sequencer counters
	typedef logic [$clog2(`CONV_TAPS)-1:0]      tap_idx_t;
	typedef logic [$clog2(`CONV_POSITIONS)-1:0] pos_idx_t;

	// One entry per output lane
	typedef weight_t weight_vec_t [`CONV_LANES];
	typedef pixel_t  ofm_vec_t    [`CONV_LANES];

	typedef struct packed {
		logic first;
		logic last;
	} tap_flags_t;

endpackage

`default_nettype wire

// ==== mac_lane.sv ====
`default_nettype none

module mac_lane (
	input  wire                           clk,
	input  wire                           arst_n,
	input  wire                           en,
	input  wire                           load,
	input  wire conv_types_pkg::pixel_t   pix,
	input  wire conv_types_pkg::weight_t  weight,
	output conv_types_pkg::acc_t          acc
);

	import conv_types_pkg::*;

	logic signed [$bits(pixel_t)+$bits(weight_t)-1:0] prod_full;
	acc_t product;

	assign prod_full = pix * weight;
	assign product   = acc_t'(prod_full);

	// First tap of a window restarts the sum
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			acc <= '0;
		end else if (en) begin
			acc <= load ? product : acc + product;
		end
	end

endmodule

`default_nettype wire

// ==== pipe_delay.sv ====
`default_nettype none

module pipe_delay #(
	parameter type T     = logic,
	parameter int  DEPTH = 1
) (
	input  wire   clk,
	input  wire   arst_n,
	input  wire T d,
	output T      q
);

	T stage [DEPTH];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < DEPTH; i++) begin
				stage[i] <= '0;
			end
		end else begin
			stage[0] <= d;
			for (int i = 1; i < DEPTH; i++) begin
				stage[i] <= stage[i-1];
			end
		end
	end

	assign q = stage[DEPTH-1];

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+.
conv_types_pkg.sv
apb_regs_pkg.sv
pipe_delay.sv
weight_rom.sv
tap_sequencer.sv
mac_lane.sv
conv_engine.sv
apb_ctrl.sv
conv_top.sv
conv_checker.sv
tb_conv_top.sv

// ==== tap_sequencer.sv ====
`default_nettype none

`include "conv_consts.svh"

module tap_sequencer (
	input  wire                       clk,
	input  wire                       arst_n,
	input  wire                       start,
	input  wire                       accept,
	output logic                      busy,
	output conv_types_pkg::tap_idx_t  tap,
	output conv_types_pkg::tap_flags_t flags,
	output conv_types_pkg::pos_idx_t  pos
);

	import conv_types_pkg::*;

	localparam tap_idx_t LAST_TAP = tap_idx_t'(`CONV_TAPS - 1);
	localparam pos_idx_t LAST_POS = pos_idx_t'(`CONV_POSITIONS - 1);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy <= 1'b0;
			tap  <= '0;
			pos  <= '0;
		end else if (start && !busy) begin
			busy <= 1'b1;
			tap  <= '0;
			pos  <= '0;
		end else if (accept) begin
			if (tap == LAST_TAP) begin
				tap <= '0;
				// Window complete, move to the next output position
				if (pos == LAST_POS) begin
					pos  <= '0;
					busy <= 1'b0;
				end else begin
					pos <= pos + 1'b1;
				end
			end else begin
				tap <= tap + 1'b1;
			end
		end
	end

	always_comb begin
		flags.first = (tap == '0);
		flags.last  = (tap == LAST_TAP);
	end

endmodule

`default_nettype wire

// ==== tb_conv_top.sv ====
`default_nettype none

`include "conv_consts.svh"

module tb_conv_top;
	timeunit 1ns;
	timeprecision 1ps;

	import apb_regs_pkg::*;
	import conv_types_pkg::*;

	localparam time CLK_PERIOD      = 40ns;
	localparam int  RUNS            = 4;
	localparam int  RUN_PIXELS      = `CONV_POSITIONS * `CONV_TAPS;
	localparam int  WATCHDOG_CYCLES = RUNS * RUN_PIXELS * 4 + 2000;
	localparam int  DONE_POLLS      = 100;
	localparam int  READY_WAIT      = 50;

	logic        clk;
	logic        arst_n;
	logic [7:0]  paddr;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;
	logic        pix_valid;
	pixel_t      pix;
	logic        pix_ready;
	logic [2:0]  test_id;
	logic        status_settled;
	int          mismatches;
	int          failures;
	int          local_failures;
	logic [31:0] rd_data;
	pixel_t      stim [RUN_PIXELS];

	always #(CLK_PERIOD / 2) clk = ~clk;

	conv_top i_dut (
		.clk       (clk),
		.arst_n    (arst_n),
		.paddr     (paddr),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.pwdata    (pwdata),
		.prdata    (prdata),
		.pready    (pready),
		.pslverr   (pslverr),
		.pix_valid (pix_valid),
		.pix       (pix),
		.pix_ready (pix_ready)
	);

	conv_checker i_chk (
		.clk            (clk),
		.arst_n         (arst_n),
		.paddr          (paddr),
		.psel           (psel),
		.penable        (penable),
		.pwrite         (pwrite),
		.pwdata         (pwdata),
		.prdata         (prdata),
		.pready         (pready),
		.pslverr        (pslverr),
		.pix_valid      (pix_valid),
		.pix            (pix),
		.pix_ready      (pix_ready),
		.test_id        (test_id),
		.status_settled (status_settled),
		.mismatches     (mismatches),
		.failures       (failures)
	);

	////////////////////////////////////////////////////////////////////////////
	// APB and pixel stream drivers
	////////////////////////////////////////////////////////////////////////////

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
		@(negedge clk);
		paddr   = addr;
		pwdata  = data;
		pwrite  = 1'b1;
		psel    = 1'b1;
		penable = 1'b0;
		@(negedge clk);
		penable = 1'b1;
		@(negedge clk);
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
		@(negedge clk);
		paddr   = addr;
		pwrite  = 1'b0;
		psel    = 1'b1;
		penable = 1'b0;
		@(negedge clk);
		penable = 1'b1;
		@(posedge clk);
		data = prdata;
		@(negedge clk);
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	// Holds each pixel until pix_ready with optional idle cycles between
	task automatic stream_pixels(input bit gaps);
		int waited;
		for (int i = 0; i < RUN_PIXELS; i++) begin
			if (gaps) begin
				repeat ($urandom_range(3, 0)) begin
					@(negedge clk);
					pix_valid = 1'b0;
				end
			end
			@(negedge clk);
			pix_valid = 1'b1;
			pix       = stim[i];
			waited    = 0;
			while (!pix_ready && waited < READY_WAIT) begin
				@(negedge clk);
				waited++;
			end
			if (!pix_ready) begin
				$display("Pixel stream stalled, pix_ready stayed low at pixel %0d", i);
				local_failures++;
				break;
			end
		end
		@(negedge clk);
		pix_valid = 1'b0;
	endtask

	task automatic wait_for_done();
		status_t st;
		int      polls;
		st    = '0;
		polls = 0;
		while (!st.done && polls < DONE_POLLS) begin
			apb_read(REG_STATUS, rd_data);
			st = status_t'(rd_data);
			polls++;
		end
		if (!st.done) begin
			$display("The layer never reported done after %0d status polls", DONE_POLLS);
			local_failures++;
		end
	endtask

	task automatic read_settled_status();
		status_settled = 1'b1;
		apb_read(REG_STATUS, rd_data);
		status_settled = 1'b0;
	endtask

	task automatic run_layer(input bit gaps);
		apb_write(REG_CTRL, 32'h1);
		read_settled_status();
		stream_pixels(gaps);
		wait_for_done();
		read_settled_status();
		for (int k = 0; k < `CONV_RESULTS; k++) begin
			apb_read(REG_RESULT_BASE + 8'(4 * k), rd_data);
		end
	endtask

	task automatic fill_random_pixels();
		for (int i = 0; i < RUN_PIXELS; i++) begin
			stim[i] = pixel_t'(int'($urandom_range(2047, 0)) - 1024);
		end
	endtask

	// Full scale values push lanes both below zero and past the output range
	task automatic fill_range_pixels();
		for (int i = 0; i < RUN_PIXELS; i++) begin
			case (i / `CONV_TAPS)
				0:       stim[i] = 16'sd32767;
				1:       stim[i] = -16'sd32768;
				2:       stim[i] = 16'sd100;
				default: stim[i] = '0;
			endcase
		end
	endtask

	initial begin
		void'($urandom(96));
		clk            = 1'b0;
		arst_n         = 1'b0;
		paddr          = '0;
		psel           = 1'b0;
		penable        = 1'b0;
		pwrite         = 1'b0;
		pwdata         = '0;
		pix_valid      = 1'b0;
		pix            = '0;
		test_id        = 3'd0;
		status_settled = 1'b0;
		local_failures = 0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;

		test_id = 3'd1;
		read_settled_status();
		@(negedge clk);
		pix_valid = 1'b1;
		pix       = 16'sh1234;
		repeat (4) @(negedge clk);
		pix_valid = 1'b0;

		test_id = 3'd2;
		fill_random_pixels();
		run_layer(1'b0);

		test_id = 3'd3;
		fill_random_pixels();
		run_layer(1'b1);

		test_id = 3'd4;
		fill_range_pixels();
		run_layer(1'b0);

		// Start clears done, then new pixels give new results
		test_id = 3'd5;
		fill_random_pixels();
		run_layer(1'b1);

		test_id = 3'd6;
		apb_read(8'h20, rd_data);
		apb_read(8'h41, rd_data);
		apb_write(REG_STATUS, 32'hffff_ffff);
		apb_write(REG_RESULT_BASE, 32'h1);
		apb_write(REG_CTRL, 32'h0);
		apb_read(REG_CTRL, rd_data);

		repeat (5) @(negedge clk);
		$display("Errors: %0d mismatches, %0d other failures", mismatches,
			failures + local_failures);
		if (mismatches == 0 && failures + local_failures == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Watchdog timeout, the run did not finish within %0d cycles",
			WATCHDOG_CYCLES);
		$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== weight_rom.sv ====
`default_nettype none

`include "conv_consts.svh"

module weight_rom (
	input  wire                           clk,
	input  wire                           arst_n,
	input  wire conv_types_pkg::tap_idx_t tap,
	output conv_types_pkg::weight_vec_t   weights,
	output conv_types_pkg::acc_t          biases [`CONV_LANES]
);

	import conv_types_pkg::*;

	weight_t wt_table [`CONV_LANES][`CONV_TAPS];

	// Fixed weight rule, small signed steps of 64
	function automatic weight_t rule_weight(input int lane, input int tap_n);
		int raw;
		raw = (lane * 7 + tap_n * 3) % 17 - 8;
		return weight_t'(raw * 64);
	endfunction

	always_comb begin
		for (int l = 0; l < `CONV_LANES; l++) begin
			for (int t = 0; t < `CONV_TAPS; t++) begin
				wt_table[l][t] = rule_weight(l, t);
			end
		end
	end

	// One tap for all lanes per cycle
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int l = 0; l < `CONV_LANES; l++) begin
				weights[l] <= '0;
			end
		end else begin
			for (int l = 0; l < `CONV_LANES; l++) begin
				weights[l] <= (tap < `CONV_TAPS) ? wt_table[l][tap] : '0;
			end
		end
	end

	always_comb begin
		for (int l = 0; l < `CONV_LANES; l++) begin
			biases[l] = acc_t'(l * 4096 - 6000);
		end
	end

endmodule

`default_nettype wire
